/* compile.f */
design/corr_num_pkg.sv
design/corr_cfg_pkg.sv
design/twiddle_table.sv
design/msdft_channel.sv
design/correlation_mults.sv
design/window_accumulator.sv
design/msdft_correlator.sv
testbench/msdft_correlator_properties.sv
testbench/tb_msdft_correlator.sv

/* design/corr_cfg_pkg.sv */
package corr_cfg_pkg;

    // comb length, also the twiddle table depth
    localparam int DFT_LEN = 16;
    localparam int TW_ADDR_W = $clog2(DFT_LEN);

    // width of the acc_len window setting
    localparam int ACC_LEN_W = 16;

    // products are shifted down by this before saturation
    localparam int CORR_SHIFT = 16;

endpackage

/* design/corr_num_pkg.sv */
package corr_num_pkg;

    // input sample, signed Q1.13
    localparam int DIN_W = 14;
    localparam int DIN_POINT = 13;

    // twiddle, signed Q2.14
    localparam int TWIDD_W = 16;
    localparam int TWIDD_POINT = 14;

    localparam int MOD_W = 18;
    localparam int BIN_W = 32;
    localparam int ACC_IN_W = 24;
    localparam int ACC_W = 40;

    // full precision of sample times twiddle, and of bin times bin
    localparam int MPROD_W = DIN_W + TWIDD_W + 1;
    localparam int PROD_W = 2 * BIN_W + 1;

    typedef struct packed {
        logic signed [DIN_W-1:0] re;
        logic signed [DIN_W-1:0] im;
    } cplx_sample_t;

    typedef struct packed {
        logic signed [TWIDD_W-1:0] re;
        logic signed [TWIDD_W-1:0] im;
    } twiddle_t;

    typedef struct packed {
        logic signed [MOD_W-1:0] re;
        logic signed [MOD_W-1:0] im;
    } mod_sample_t;

    typedef struct packed {
        logic signed [BIN_W-1:0] re;
        logic signed [BIN_W-1:0] im;
    } bin_t;

    typedef struct packed {
        logic signed [ACC_IN_W-1:0] r12_re;
        logic signed [ACC_IN_W-1:0] r12_im;
        logic [ACC_IN_W-1:0]        r11;
        logic [ACC_IN_W-1:0]        r22;
    } corr_terms_t;

    typedef struct packed {
        logic signed [ACC_W-1:0] r12_re;
        logic signed [ACC_W-1:0] r12_im;
        logic [ACC_W-1:0]        r11;
        logic [ACC_W-1:0]        r22;
    } corr_result_t;

endpackage

/* design/correlation_mults.sv */
`timescale 1ns/1ps

module correlation_mults
    import corr_num_pkg::*;
    import corr_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  bin_t        bin1,
    input  bin_t        bin2,
    input  logic        valid,
    output corr_terms_t terms,
    output logic        terms_valid
);

    logic signed [PROD_W-1:0] p12_re;
    logic signed [PROD_W-1:0] p12_im;
    logic signed [PROD_W-1:0] p11;
    logic signed [PROD_W-1:0] p22;
    logic                     prod_valid;

    function automatic logic signed [ACC_IN_W-1:0] sat_signed(
        input logic signed [PROD_W-1:0] x
    );
        logic signed [PROD_W-1:0] s;
        s = x >>> CORR_SHIFT;
        // fits when all bits above the sign agree
        if (&s[PROD_W-1:ACC_IN_W-1] || ~|s[PROD_W-1:ACC_IN_W-1]) begin
            return s[ACC_IN_W-1:0];
        end else if (s[PROD_W-1]) begin
            return {1'b1, {(ACC_IN_W-1){1'b0}}};
        end else begin
            return {1'b0, {(ACC_IN_W-1){1'b1}}};
        end
    endfunction

    // powers are never negative
    function automatic logic [ACC_IN_W-1:0] sat_unsigned(input logic signed [PROD_W-1:0] x);
        logic signed [PROD_W-1:0] s;
        s = x >>> CORR_SHIFT;
        if (|s[PROD_W-1:ACC_IN_W]) begin
            return '1;
        end else begin
            return s[ACC_IN_W-1:0];
        end
    endfunction

    // bin1 * conj(bin2), |bin1|^2, |bin2|^2
    always_ff @(posedge clk) begin
        p12_re <= bin1.re * bin2.re + bin1.im * bin2.im;
        p12_im <= bin1.im * bin2.re - bin1.re * bin2.im;
        p11 <= bin1.re * bin1.re + bin1.im * bin1.im;
        p22 <= bin2.re * bin2.re + bin2.im * bin2.im;
    end

    always_ff @(posedge clk) begin
        terms.r12_re <= sat_signed(p12_re);
        terms.r12_im <= sat_signed(p12_im);
        terms.r11 <= sat_unsigned(p11);
        terms.r22 <= sat_unsigned(p22);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prod_valid <= 1'b0;
            terms_valid <= 1'b0;
        end else begin
            prod_valid <= valid;
            terms_valid <= prod_valid;
        end
    end

endmodule

/* design/msdft_channel.sv */
`timescale 1ns/1ps

module msdft_channel
    import corr_num_pkg::*;
    import corr_cfg_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  cplx_sample_t sample,
    input  twiddle_t     twiddle,
    input  logic         valid,
    output bin_t         bin,
    output logic         bin_valid
);

    logic signed [MPROD_W-1:0] prod_re;
    logic signed [MPROD_W-1:0] prod_im;
    logic signed [MPROD_W-1:0] shift_re;
    logic signed [MPROD_W-1:0] shift_im;
    mod_sample_t               mod;
    logic                      mod_valid;
    mod_sample_t               hist [DFT_LEN];
    mod_sample_t               oldest;

    // complex modulation, floor back to twiddle scale
    always_comb begin
        prod_re = sample.re * twiddle.re - sample.im * twiddle.im;
        prod_im = sample.re * twiddle.im + sample.im * twiddle.re;
        shift_re = prod_re >>> TWIDD_POINT;
        shift_im = prod_im >>> TWIDD_POINT;
    end

    always_ff @(posedge clk) begin
        mod.re <= shift_re[MOD_W-1:0];
        mod.im <= shift_im[MOD_W-1:0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mod_valid <= 1'b0;
        end else begin
            mod_valid <= valid;
        end
    end

    // comb delay line
    // fills with zeros for as long as the flush holds reset
    always_ff @(posedge clk) begin
        if (rst || mod_valid) begin
            hist[0] <= rst ? '0 : mod;
            for (int i = 1; i < DFT_LEN; i++) begin
                hist[i] <= hist[i-1];
            end
        end
    end

    assign oldest = hist[DFT_LEN-1];

    // integrator, sum of the last DFT_LEN modulated samples
    always_ff @(posedge clk) begin
        if (rst) begin
            bin <= '0;
            bin_valid <= 1'b0;
        end else begin
            bin_valid <= mod_valid;
            if (mod_valid) begin
                bin.re <= bin.re + mod.re - oldest.re;
                bin.im <= bin.im + mod.im - oldest.im;
            end
        end
    end

endmodule

/* design/msdft_correlator.sv */
`timescale 1ns/1ps

module msdft_correlator
    import corr_num_pkg::*;
    import corr_cfg_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  cplx_sample_t         din1,
    input  cplx_sample_t         din2,
    input  logic                 din_valid,
    input  logic [ACC_LEN_W-1:0] acc_len,
    input  logic                 twidd_we,
    input  logic [TW_ADDR_W-1:0] twidd_addr,
    input  twiddle_t             twidd_data,
    output corr_result_t         result,
    output logic                 dout_valid,
    output logic                 ready
);

    logic [TW_ADDR_W:0] flush_cnt;
    logic               flushing;
    logic               chan_rst;
    logic               sample_strobe;
    cplx_sample_t       din1_r;
    cplx_sample_t       din2_r;
    twiddle_t           twiddle;
    logic               twiddle_valid;
    bin_t               bin1;
    bin_t               bin2;
    logic               bin1_valid;
    logic               bin2_valid;
    corr_terms_t        terms;
    logic               terms_valid;

    // flush runs through reset and DFT_LEN cycles after it
    always_ff @(posedge clk) begin
        if (rst) begin
            flush_cnt <= '0;
        end else if (!ready) begin
            flush_cnt <= flush_cnt + 1'b1;
        end
    end

    assign ready = (flush_cnt == (TW_ADDR_W + 1)'(DFT_LEN));
    assign flushing = rst || !ready;

    // zero samples with valid high while flushing, input ignored
    assign sample_strobe = flushing || din_valid;

    // the registered valid comes back from the table as twiddle_valid
    always_ff @(posedge clk) begin
        chan_rst <= flushing;
        if (flushing) begin
            din1_r <= '0;
            din2_r <= '0;
        end else begin
            din1_r <= din1;
            din2_r <= din2;
        end
    end

    twiddle_table u_twiddle_table (
        .clk           (clk),
        .rst           (rst),
        .sample_strobe (sample_strobe),
        .twidd_we      (twidd_we),
        .twidd_addr    (twidd_addr),
        .twidd_data    (twidd_data),
        .twiddle       (twiddle),
        .twiddle_valid (twiddle_valid)
    );

    msdft_channel u_channel1 (
        .clk       (clk),
        .rst       (chan_rst),
        .sample    (din1_r),
        .twiddle   (twiddle),
        .valid     (twiddle_valid),
        .bin       (bin1),
        .bin_valid (bin1_valid)
    );

    msdft_channel u_channel2 (
        .clk       (clk),
        .rst       (chan_rst),
        .sample    (din2_r),
        .twiddle   (twiddle),
        .valid     (twiddle_valid),
        .bin       (bin2),
        .bin_valid (bin2_valid)
    );

    correlation_mults u_corr_mults (
        .clk         (clk),
        .rst         (rst),
        .bin1        (bin1),
        .bin2        (bin2),
        .valid       (bin1_valid && bin2_valid),
        .terms       (terms),
        .terms_valid (terms_valid)
    );

    window_accumulator u_window_acc (
        .clk         (clk),
        .rst         (rst),
        .clear       (!ready),
        .terms       (terms),
        .terms_valid (terms_valid),
        .acc_len     (acc_len),
        .result      (result),
        .dout_valid  (dout_valid)
    );

endmodule

/* design/twiddle_table.sv */
`timescale 1ns/1ps

module twiddle_table
    import corr_num_pkg::*;
    import corr_cfg_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 sample_strobe,
    input  logic                 twidd_we,
    input  logic [TW_ADDR_W-1:0] twidd_addr,
    input  twiddle_t             twidd_data,
    output twiddle_t             twiddle,
    output logic                 twiddle_valid
);

    twiddle_t             ram [DFT_LEN];
    logic [TW_ADDR_W-1:0] index;

    // one read port shared by both channels
    always_ff @(posedge clk) begin
        if (twidd_we) begin
            ram[twidd_addr] <= twidd_data;
        end
        twiddle <= ram[index];
    end

    // modulation index, wraps at DFT_LEN
    always_ff @(posedge clk) begin
        if (rst) begin
            index <= '0;
            twiddle_valid <= 1'b0;
        end else begin
            twiddle_valid <= sample_strobe;
            if (sample_strobe) begin
                index <= index + 1'b1;
            end
        end
    end

endmodule

/* design/window_accumulator.sv */
`timescale 1ns/1ps

module window_accumulator
    import corr_num_pkg::*;
    import corr_cfg_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 clear,
    input  corr_terms_t          terms,
    input  logic                 terms_valid,
    input  logic [ACC_LEN_W-1:0] acc_len,
    output corr_result_t         result,
    output logic                 dout_valid
);

    logic [ACC_LEN_W-1:0] count;
    logic [ACC_LEN_W-1:0] len_q;
    logic [ACC_LEN_W-1:0] cur_len;
    logic                 first;
    logic                 last;
    corr_result_t         acc;
    corr_result_t         acc_next;

    // window length is taken with the first term, 0 counts as 1
    always_comb begin
        first = (count == '0);
        if (first) begin
            cur_len = (acc_len == '0) ? ACC_LEN_W'(1) : acc_len;
        end else begin
            cur_len = len_q;
        end
        last = (count + 1'b1 == cur_len);
    end

    always_comb begin
        acc_next.r12_re = (first ? '0 : acc.r12_re) + ACC_W'(terms.r12_re);
        acc_next.r12_im = (first ? '0 : acc.r12_im) + ACC_W'(terms.r12_im);
        acc_next.r11 = (first ? '0 : acc.r11) + ACC_W'(terms.r11);
        acc_next.r22 = (first ? '0 : acc.r22) + ACC_W'(terms.r22);
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            count <= '0;
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= terms_valid && last;
            if (terms_valid) begin
                count <= last ? '0 : count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (terms_valid) begin
            acc <= acc_next;
            if (first) begin
                len_q <= cur_len;
            end
            if (last) begin
                result <= acc_next;
            end
        end
    end

endmodule

/* testbench/msdft_correlator_properties.sv */
`timescale 1ns/1ps

module msdft_correlator_properties
    import corr_num_pkg::*;
    import corr_cfg_pkg::*;
(
    input logic         clk,
    input logic         rst,
    input logic         ready,
    input logic         dout_valid,
    input corr_result_t result
);

    int fail_count = 0;

    // a window can only finish once the flush is over
    dout_after_flush: assert property (@(posedge clk) disable iff (rst)
        $rose(dout_valid) |-> ready)
    else begin
        fail_count++;
        $error("dout_valid rose while ready was low");
    end

    // flush lasts at least DFT_LEN cycles after reset
    flush_length: assert property (@(posedge clk)
        $fell(rst) |-> !ready [*DFT_LEN])
    else begin
        fail_count++;
        $error("ready rose fewer than DFT_LEN cycles after reset");
    end

    result_known: assert property (@(posedge clk) disable iff (rst)
        dout_valid |-> !$isunknown(result))
    else begin
        fail_count++;
        $error("result has unknown bits while dout_valid is high");
    end

endmodule

bind msdft_correlator msdft_correlator_properties u_props (
    .clk        (clk),
    .rst        (rst),
    .ready      (ready),
    .dout_valid (dout_valid),
    .result     (result)
);

/* testbench/tb_msdft_correlator.sv */
`timescale 1ns/1ps

module tb_msdft_correlator
    import corr_num_pkg::*;
    import corr_cfg_pkg::*;
();

    logic                 clk;
    logic                 rst;
    cplx_sample_t         din1;
    cplx_sample_t         din2;
    logic                 din_valid;
    logic [ACC_LEN_W-1:0] acc_len;
    logic                 twidd_we;
    logic [TW_ADDR_W-1:0] twidd_addr;
    twiddle_t             twidd_data;
    corr_result_t         result;
    logic                 dout_valid;
    logic                 ready;

    logic [31:0]  rng_state = 32'hdcdc9e9b;
    string        test_name = "init";
    int           check_errors = 0;
    int           timeout_errors = 0;
    int           dout_count = 0;
    corr_result_t last_result;
    corr_result_t exp_q [$];

    // reference model state
    twiddle_t tw_model [DFT_LEN];
    longint   hist_re [2][DFT_LEN];
    longint   hist_im [2][DFT_LEN];
    int       hpos;
    int       m_index;
    int       win_count;
    int       win_len;
    longint   sum_r12_re;
    longint   sum_r12_im;
    longint   sum_r11;
    longint   sum_r22;

    msdft_correlator uut (
        .clk        (clk),
        .rst        (rst),
        .din1       (din1),
        .din2       (din2),
        .din_valid  (din_valid),
        .acc_len    (acc_len),
        .twidd_we   (twidd_we),
        .twidd_addr (twidd_addr),
        .twidd_data (twidd_data),
        .result     (result),
        .dout_valid (dout_valid),
        .ready      (ready)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // 12-bit samples keep the products clear of saturation
    function automatic cplx_sample_t rand_sample();
        cplx_sample_t s;
        logic [31:0]  r;
        r = next_rand();
        s.re = $signed(r[11:0]);
        s.im = $signed(r[27:16]);
        return s;
    endfunction

    function automatic longint clamp_signed(input longint p);
        longint s;
        longint lim;
        s = p >>> CORR_SHIFT;
        lim = longint'(1) <<< (ACC_IN_W - 1);
        if (s >= lim) begin
            return lim - 1;
        end else if (s < -lim) begin
            return -lim;
        end
        return s;
    endfunction

    function automatic longint clamp_power(input longint p);
        longint s;
        longint lim;
        s = p >>> CORR_SHIFT;
        lim = longint'(1) <<< ACC_IN_W;
        if (s >= lim) begin
            return lim - 1;
        end
        return s;
    endfunction

    task automatic check(input string what, input longint expected, input longint actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s %s: expected %0d, actual %0d",
                     test_name, what, expected, actual);
            check_errors++;
        end
    endtask

    always @(negedge clk) begin
        corr_result_t e;
        if (dout_valid === 1'b1) begin
            dout_count++;
            last_result = result;
            if (!ready) begin
                $display("%s: dout_valid was high while ready was low", test_name);
                check_errors++;
            end
            if (exp_q.size() == 0) begin
                $display("%s: dout_valid arrived with no window expected", test_name);
                check_errors++;
            end else begin
                e = exp_q.pop_front();
                check("r12_re", longint'(e.r12_re), longint'(result.r12_re));
                check("r12_im", longint'(e.r12_im), longint'(result.r12_im));
                check("r11", longint'(e.r11), longint'(result.r11));
                check("r22", longint'(e.r22), longint'(result.r22));
            end
        end
    end

    task automatic model_reset();
        foreach (hist_re[c, i]) begin
            hist_re[c][i] = 0;
            hist_im[c][i] = 0;
        end
        hpos = 0;
        m_index = 0;
        win_count = 0;
    endtask

    task automatic model_sample(input cplx_sample_t a, input cplx_sample_t b);
        cplx_sample_t s [2];
        twiddle_t     t;
        longint       br [2];
        longint       bi [2];
        longint       p12_re;
        longint       p12_im;
        corr_result_t e;
        s[0] = a;
        s[1] = b;
        t = tw_model[m_index];
        for (int c = 0; c < 2; c++) begin
            hist_re[c][hpos] = (longint'(s[c].re) * longint'(t.re)
                - longint'(s[c].im) * longint'(t.im)) >>> TWIDD_POINT;
            hist_im[c][hpos] = (longint'(s[c].re) * longint'(t.im)
                + longint'(s[c].im) * longint'(t.re)) >>> TWIDD_POINT;
            br[c] = 0;
            bi[c] = 0;
        end
        hpos = (hpos + 1) % DFT_LEN;
        m_index = (m_index + 1) % DFT_LEN;
        // bin is the plain sum of the last DFT_LEN modulated samples
        for (int c = 0; c < 2; c++) begin
            for (int i = 0; i < DFT_LEN; i++) begin
                br[c] += hist_re[c][i];
                bi[c] += hist_im[c][i];
            end
        end
        p12_re = br[0] * br[1] + bi[0] * bi[1];
        p12_im = bi[0] * br[1] - br[0] * bi[1];
        if (win_count == 0) begin
            win_len = (acc_len == 0) ? 1 : int'(acc_len);
            sum_r12_re = 0;
            sum_r12_im = 0;
            sum_r11 = 0;
            sum_r22 = 0;
        end
        sum_r12_re += clamp_signed(p12_re);
        sum_r12_im += clamp_signed(p12_im);
        sum_r11 += clamp_power(br[0] * br[0] + bi[0] * bi[0]);
        sum_r22 += clamp_power(br[1] * br[1] + bi[1] * bi[1]);
        win_count++;
        if (win_count == win_len) begin
            e.r12_re = ACC_W'(sum_r12_re);
            e.r12_im = ACC_W'(sum_r12_im);
            e.r11 = ACC_W'(sum_r11);
            e.r22 = ACC_W'(sum_r22);
            exp_q.push_back(e);
            win_count = 0;
        end
    endtask

    task automatic drive_sample(input cplx_sample_t a, input cplx_sample_t b, input logic v);
        @(negedge clk);
        din1 = a;
        din2 = b;
        din_valid = v;
        if (v && ready) begin
            model_sample(a, b);
        end
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            drive_sample(rand_sample(), rand_sample(), 1'b0);
        end
    endtask

    task automatic write_twiddle(input int addr, input twiddle_t t);
        @(negedge clk);
        din_valid = 1'b0;
        twidd_we = 1'b1;
        twidd_addr = TW_ADDR_W'(addr);
        twidd_data = t;
        tw_model[addr] = t;
    endtask

    task automatic load_unit_twiddles();
        twiddle_t t;
        t.re = 16'sd16384;
        t.im = '0;
        for (int i = 0; i < DFT_LEN; i++) begin
            write_twiddle(i, t);
        end
        @(negedge clk);
        twidd_we = 1'b0;
    endtask

    task automatic load_random_twiddles();
        twiddle_t    t;
        logic [31:0] r;
        for (int i = 0; i < DFT_LEN; i++) begin
            r = next_rand();
            t.re = $signed(r[14:0]);
            t.im = $signed(r[30:16]);
            write_twiddle(i, t);
        end
        @(negedge clk);
        twidd_we = 1'b0;
    endtask

    // junk samples are offered through reset and flush when asked
    task automatic reset_dut(input logic junk);
        int cycles;
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            rst = 1'b1;
            din1 = rand_sample();
            din2 = rand_sample();
            din_valid = junk;
        end
        @(negedge clk);
        rst = 1'b0;
        model_reset();
        cycles = 0;
        while (!ready && cycles < 4 * DFT_LEN) begin
            @(negedge clk);
            cycles++;
            din1 = rand_sample();
            din2 = rand_sample();
            din_valid = ready ? 1'b0 : junk;
        end
        if (!ready) begin
            $display("%s: ready did not rise after reset", test_name);
            timeout_errors++;
        end else begin
            check("flush cycles", DFT_LEN, cycles);
        end
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < 400) begin
            @(negedge clk);
            din_valid = 1'b0;
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("%s: %0d expected windows never came out", test_name, exp_q.size());
            timeout_errors++;
            exp_q.delete();
        end
        idle_cycles(8);
    endtask

    task automatic test_flush();
        int start;
        test_name = "test_flush";
        acc_len = 4;
        load_unit_twiddles();
        reset_dut(1'b1);
        start = dout_count;
        for (int i = 0; i < 8; i++) begin
            drive_sample(rand_sample(), rand_sample(), 1'b1);
        end
        wait_drained();
        check("windows", 2, dout_count - start);
    endtask

    task automatic test_dc_unit_twiddle();
        cplx_sample_t a;
        cplx_sample_t b;
        longint       bin_a;
        longint       bin_b;
        longint       n;
        test_name = "test_dc_unit_twiddle";
        a.re = 14'sd1000;
        a.im = '0;
        b.re = -14'sd600;
        b.im = '0;
        acc_len = 16;
        load_unit_twiddles();
        for (int i = 0; i < 4 * 16; i++) begin
            drive_sample(a, b, 1'b1);
        end
        wait_drained();
        // a full comb holds DFT_LEN copies of each input
        bin_a = DFT_LEN * longint'(a.re);
        bin_b = DFT_LEN * longint'(b.re);
        n = longint'(acc_len);
        check("steady r11", n * ((bin_a * bin_a) >>> CORR_SHIFT),
              longint'(last_result.r11));
        check("steady r22", n * ((bin_b * bin_b) >>> CORR_SHIFT),
              longint'(last_result.r22));
        check("steady r12_re", n * ((bin_a * bin_b) >>> CORR_SHIFT),
              longint'(last_result.r12_re));
        check("steady r12_im", 0, longint'(last_result.r12_im));
    endtask

    task automatic test_quadrature();
        cplx_sample_t a;
        cplx_sample_t b;
        test_name = "test_quadrature";
        acc_len = 16;
        for (int i = 0; i < 32; i++) begin
            a = rand_sample();
            b.re = -a.im;
            b.im = a.re;
            drive_sample(a, b, 1'b1);
        end
        wait_drained();
        check("r12_re zero", 0, longint'(last_result.r12_re));
        check("r12_im negative", 1, longint'(last_result.r12_im < 0));
    endtask

    task automatic test_random_twiddles();
        int start;
        test_name = "test_random_twiddles";
        load_random_twiddles();
        acc_len = 10;
        start = dout_count;
        for (int i = 0; i < 50; i++) begin
            drive_sample(rand_sample(), rand_sample(), 1'b1);
        end
        wait_drained();
        check("windows", 5, dout_count - start);
    endtask

    task automatic test_window_len_and_gaps();
        int start;
        int n;
        test_name = "test_window_len_and_gaps";
        start = dout_count;
        for (int w = 0; w < 6; w++) begin
            acc_len = (w == 0) ? '0 : ACC_LEN_W'(1 + next_rand() % 9);
            n = (acc_len == 0) ? 1 : int'(acc_len);
            for (int i = 0; i < n; i++) begin
                drive_sample(rand_sample(), rand_sample(), 1'b1);
                idle_cycles(next_rand() % 4);
            end
            wait_drained();
        end
        check("windows", 6, dout_count - start);
    endtask

    task automatic test_midstream_reset();
        int start;
        test_name = "test_midstream_reset";
        acc_len = 12;
        for (int i = 0; i < 7; i++) begin
            drive_sample(rand_sample(), rand_sample(), 1'b1);
        end
        reset_dut(1'b0);
        start = dout_count;
        for (int i = 0; i < 24; i++) begin
            drive_sample(rand_sample(), rand_sample(), 1'b1);
        end
        wait_drained();
        check("windows", 2, dout_count - start);
    endtask

    initial begin
        int assert_errors;
        clk = 1'b0;
        rst = 1'b1;
        din1 = '0;
        din2 = '0;
        din_valid = 1'b0;
        acc_len = 16;
        twidd_we = 1'b0;
        twidd_addr = '0;
        twidd_data = '0;
        model_reset();

        test_flush();
        test_dc_unit_twiddle();
        test_quadrature();
        test_random_twiddles();
        test_window_len_and_gaps();
        test_midstream_reset();

        assert_errors = uut.u_props.fail_count;
        $display("errors: %0d check, %0d timeout, %0d assertion",
                 check_errors, timeout_errors, assert_errors);
        if (check_errors + timeout_errors + assert_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
